/* upct_pkg.sv */
/*
 * Geometry of the upper PC table and its tree pseudo-LRU.
 * The entry count must be a power of two, at least 2.
 * The tree state holds one bit per internal node, so entries minus one.
 * Compile this package before pc_pkg, which uses the index type.
 */

package upct_pkg;

    // ------------------------------------------------------------------------
    // table geometry
    // ------------------------------------------------------------------------

    // number of upper PC entries held in flops
    localparam int UPCT_ENTRIES = 8;

    // bits needed to name one entry
    localparam int UPCT_IDX_WIDTH = $clog2(UPCT_ENTRIES);

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------

    // table index as carried in compressed targets
    typedef logic [UPCT_IDX_WIDTH-1:0] upct_idx_t;

    // tree pseudo-LRU state
    // node 0 is the root, children of node k sit at 2k+1 and 2k+2
    // bit 0 points left, bit 1 points right
    typedef logic [UPCT_ENTRIES-2:0] plru_t;

endpackage

/* pc_pkg.sv */
/*
 * Program counter widths and the target structs built from them.
 * A full PC splits into an upper part (UPC) and a lower part (LPC).
 * Compressed targets keep only a table index in place of the UPC.
 * Depends on upct_pkg for the index type.
 */

package pc_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------

    // full program counter
    localparam int PC_WIDTH = 32;

    // low bits kept beside the table index
    localparam int LPC_WIDTH = 10;

    // upper bits stored in the table
    localparam int UPC_WIDTH = PC_WIDTH - LPC_WIDTH;

    // ------------------------------------------------------------------------
    // plain vector types
    // ------------------------------------------------------------------------

    typedef logic [PC_WIDTH-1:0]  pc_t;
    typedef logic [UPC_WIDTH-1:0] upc_t;
    typedef logic [LPC_WIDTH-1:0] lpc_t;

    // ------------------------------------------------------------------------
    // target structs
    // ------------------------------------------------------------------------

    // compressed target, index in the upper bits, lpc below
    typedef struct packed {
        upct_pkg::upct_idx_t index;
        lpc_t                lpc;
    } comp_target_t;

    // expanded target with its valid bit on top
    typedef struct packed {
        logic valid;
        pc_t  pc;
    } full_target_t;

endpackage

/* one_hot_enc.sv */
/*
 * One-hot to binary encoder.
 * WIDTH must be a power of two and at least 2.
 * With more than one bit set the index is the OR of all set positions,
 * so the result is only exact for a true one-hot input.
 */

module one_hot_enc #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         one_hot_in,
    output logic                     valid_out,
    output logic [$clog2(WIDTH)-1:0] index_out
);

    // ------------------------------------------------------------------------
    // valid
    // ------------------------------------------------------------------------

    // any set bit counts as a hit
    assign valid_out = |one_hot_in;

    // ------------------------------------------------------------------------
    // index
    // ------------------------------------------------------------------------

    // OR together the positions of every set bit
    // no priority between bits
    always_comb begin
        index_out = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (one_hot_in[i]) begin
                index_out = index_out | ($clog2(WIDTH))'(i);
            end
        end
    end

endmodule

/* plru_updater.sv */
/*
 * Binary-tree pseudo-LRU, purely combinational.
 * The victim is the leaf reached by following the state bits from the
 * root, 0 going left and 1 going right.
 * A fill takes priority over a touch, and with neither the state holds.
 * Geometry comes from upct_pkg.
 */

module plru_updater (
    input  upct_pkg::plru_t     plru_in,
    input  logic                new_valid,
    output upct_pkg::upct_idx_t new_index,
    input  logic                touch_valid,
    input  upct_pkg::upct_idx_t touch_index,
    output upct_pkg::plru_t     plru_out
);

    // ------------------------------------------------------------------------
    // tree helpers
    // ------------------------------------------------------------------------

    // walk from the root along the state bits
    // each level contributes one index bit, msb first
    function automatic upct_pkg::upct_idx_t victim_of(
        input upct_pkg::plru_t state
    );
        upct_pkg::upct_idx_t idx;
        int unsigned         node;
        idx  = '0;
        node = 0;
        for (int lvl = 0; lvl < upct_pkg::UPCT_IDX_WIDTH; lvl++) begin
            idx[upct_pkg::UPCT_IDX_WIDTH-1-lvl] = state[node];
            // step to left or right child
            node = 2 * node + 1 + state[node];
        end
        return idx;
    endfunction

    // make every node on the path to idx point at the other branch
    function automatic upct_pkg::plru_t point_away(
        input upct_pkg::plru_t     state,
        input upct_pkg::upct_idx_t idx
    );
        upct_pkg::plru_t next_state;
        int unsigned     node;
        logic            branch;
        next_state = state;
        node       = 0;
        for (int lvl = 0; lvl < upct_pkg::UPCT_IDX_WIDTH; lvl++) begin
            // branch taken at this level
            branch = idx[upct_pkg::UPCT_IDX_WIDTH-1-lvl];
            next_state[node] = ~branch;
            node = 2 * node + 1 + branch;
        end
        return next_state;
    endfunction

    // ------------------------------------------------------------------------
    // victim and next state
    // ------------------------------------------------------------------------

    // current victim, always presented
    assign new_index = victim_of(plru_in);

    always_comb begin
        // hold unless something happens
        plru_out = plru_in;
        if (new_valid) begin
            // fill lands on the victim, so move past it
            plru_out = point_away(plru_in, new_index);
        end
        else if (touch_valid) begin
            plru_out = point_away(plru_in, touch_index);
        end
    end

endmodule

/* upct.sv */
/*
 * Upper program counter table, a small CAM in flops.
 * Update searches all entries; a hit reports the matching index, a miss
 * writes the pseudo-LRU victim and reports that index.
 * Both result paths are combinational, state changes on the next edge.
 * A read in the same cycle sees the contents from before that edge.
 * Duplicate matches OR their indices, only possible for the reset UPC.
 */

module upct (
    // clock and reset
    input  logic                CLK,
    input  logic                nRST,

    // read request
    input  logic                read_valid,
    input  upct_pkg::upct_idx_t read_index,

    // read result
    output pc_pkg::upc_t        read_upc,

    // update request
    input  logic                update_valid,
    input  pc_pkg::upc_t        update_upc,

    // update result
    output upct_pkg::upct_idx_t update_upct_index
);

    // ------------------------------------------------------------------------
    // signals
    // ------------------------------------------------------------------------

    // entry storage
    pc_pkg::upc_t upct_array      [upct_pkg::UPCT_ENTRIES];
    pc_pkg::upc_t next_upct_array [upct_pkg::UPCT_ENTRIES];

    // recency tree
    upct_pkg::plru_t plru;
    upct_pkg::plru_t next_plru;

    // pseudo-LRU controls
    logic                plru_new_valid;
    upct_pkg::upct_idx_t plru_new_index;
    logic                plru_touch_valid;
    upct_pkg::upct_idx_t plru_touch_index;

    // search results
    logic [upct_pkg::UPCT_ENTRIES-1:0] match_by_entry;
    logic                              have_match;
    upct_pkg::upct_idx_t               match_index;

    // ------------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // all entries start at upc zero
            for (int i = 0; i < upct_pkg::UPCT_ENTRIES; i++) begin
                upct_array[i] <= '0;
            end
            // first victim is entry 0
            plru <= '0;
        end
        else begin
            upct_array <= next_upct_array;
            plru       <= next_plru;
        end
    end

    // ------------------------------------------------------------------------
    // read
    // ------------------------------------------------------------------------

    // plain indexed lookup of current contents
    assign read_upc = upct_array[read_index];

    // ------------------------------------------------------------------------
    // search
    // ------------------------------------------------------------------------

    // compare against every entry in parallel
    always_comb begin
        for (int i = 0; i < upct_pkg::UPCT_ENTRIES; i++) begin
            match_by_entry[i] = (upct_array[i] == update_upc);
        end
    end

    one_hot_enc #(
        .WIDTH(upct_pkg::UPCT_ENTRIES)
    ) u_match_enc (
        .one_hot_in(match_by_entry),
        .valid_out (have_match),
        .index_out (match_index)
    );

    // ------------------------------------------------------------------------
    // array and recency control
    // ------------------------------------------------------------------------

    always_comb begin
        // hold contents and tree by default
        next_upct_array   = upct_array;
        plru_new_valid    = 1'b0;
        plru_touch_valid  = 1'b0;
        plru_touch_index  = read_index;
        // victim advertised when nothing else applies
        update_upct_index = plru_new_index;

        if (update_valid && have_match) begin
            // hit, nothing written
            update_upct_index = match_index;
            plru_touch_valid  = 1'b1;
            plru_touch_index  = match_index;
        end
        else if (update_valid) begin
            // miss, victim takes the new upc
            next_upct_array[plru_new_index] = update_upc;
            plru_new_valid = 1'b1;
        end
        else if (read_valid) begin
            // read only refreshes when no update owns the tree
            plru_touch_valid = 1'b1;
        end
    end

    plru_updater u_plru (
        .plru_in    (plru),
        .new_valid  (plru_new_valid),
        .new_index  (plru_new_index),
        .touch_valid(plru_touch_valid),
        .touch_index(plru_touch_index),
        .plru_out   (next_plru)
    );

endmodule

/* target_compressor.sv */
/*
 * Input side of the target table.
 * Splits an update PC into UPC and LPC and sends the UPC to the table.
 * The table index comes back in the same cycle and is registered with
 * the LPC, so comp_valid follows update_valid by exactly one cycle.
 * comp_target keeps its last value while comp_valid is low.
 */

module target_compressor (
    // clock and reset
    input  logic                 CLK,
    input  logic                 nRST,

    // update from the front end
    input  logic                 update_valid,
    input  pc_pkg::pc_t          update_pc,

    // table side
    output logic                 tbl_update_valid,
    output pc_pkg::upc_t         tbl_update_upc,
    input  upct_pkg::upct_idx_t  tbl_update_index,

    // compressed result
    output logic                 comp_valid,
    output pc_pkg::comp_target_t comp_target
);

    // ------------------------------------------------------------------------
    // split
    // ------------------------------------------------------------------------

    // low bits stay here while the table resolves the index
    pc_pkg::lpc_t update_lpc;

    assign update_lpc       = update_pc[pc_pkg::LPC_WIDTH-1:0];
    assign tbl_update_upc   = update_pc[pc_pkg::PC_WIDTH-1:pc_pkg::LPC_WIDTH];
    assign tbl_update_valid = update_valid;

    // ------------------------------------------------------------------------
    // result registers
    // ------------------------------------------------------------------------

    // strobe
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            comp_valid <= 1'b0;
        end
        else begin
            comp_valid <= update_valid;
        end
    end

    // payload, loads only on an update
    always_ff @(posedge CLK) begin
        if (update_valid) begin
            comp_target.index <= tbl_update_index;
            comp_target.lpc   <= update_lpc;
        end
    end

endmodule

/* target_expander.sv */
/*
 * Output side of the target table.
 * Sends the index of a compressed target to the table and joins the
 * returned UPC with the target's LPC.
 * expanded.valid follows read_valid by exactly one cycle.
 * The PC field keeps its last value while valid is low.
 */

module target_expander (
    // clock and reset
    input  logic                 CLK,
    input  logic                 nRST,

    // compressed target to expand
    input  logic                 read_valid,
    input  pc_pkg::comp_target_t read_target,

    // table side
    output logic                 tbl_read_valid,
    output upct_pkg::upct_idx_t  tbl_read_index,
    input  pc_pkg::upc_t         tbl_read_upc,

    // expanded result
    output pc_pkg::full_target_t expanded
);

    // registered halves of the result
    logic        valid_q;
    pc_pkg::pc_t pc_q;

    // ------------------------------------------------------------------------
    // table request
    // ------------------------------------------------------------------------

    assign tbl_read_valid = read_valid;
    assign tbl_read_index = read_target.index;

    // ------------------------------------------------------------------------
    // result registers
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end
        else begin
            valid_q <= read_valid;
        end
    end

    // upc from the table above the lpc carried in the target
    always_ff @(posedge CLK) begin
        if (read_valid) begin
            pc_q <= {tbl_read_upc, read_target.lpc};
        end
    end

    assign expanded.valid = valid_q;
    assign expanded.pc    = pc_q;

endmodule

/* pc_table_top.sv */
/*
 * Branch target compression subsystem.
 * Updates return a compressed target one cycle later; reads expand a
 * compressed target into a full PC one cycle later.
 * Plain strobes only, no back-pressure; results last one cycle.
 */

module pc_table_top (
    // clock and reset
    input  logic                 CLK,
    input  logic                 nRST,

    // compress path
    input  logic                 update_valid,
    input  pc_pkg::pc_t          update_pc,
    output logic                 comp_valid,
    output pc_pkg::comp_target_t comp_target,

    // expand path
    input  logic                 read_valid,
    input  pc_pkg::comp_target_t read_target,
    output pc_pkg::full_target_t expanded
);

    // ------------------------------------------------------------------------
    // table links
    // ------------------------------------------------------------------------

    // update side
    logic                tbl_update_valid;
    pc_pkg::upc_t        tbl_update_upc;
    upct_pkg::upct_idx_t tbl_update_index;

    // read side
    logic                tbl_read_valid;
    upct_pkg::upct_idx_t tbl_read_index;
    pc_pkg::upc_t        tbl_read_upc;

    // ------------------------------------------------------------------------
    // instances
    // ------------------------------------------------------------------------

    target_compressor u_compressor (
        .CLK             (CLK),
        .nRST            (nRST),
        .update_valid    (update_valid),
        .update_pc       (update_pc),
        .tbl_update_valid(tbl_update_valid),
        .tbl_update_upc  (tbl_update_upc),
        .tbl_update_index(tbl_update_index),
        .comp_valid      (comp_valid),
        .comp_target     (comp_target)
    );

    upct u_upct (
        .CLK              (CLK),
        .nRST             (nRST),
        .read_valid       (tbl_read_valid),
        .read_index       (tbl_read_index),
        .read_upc         (tbl_read_upc),
        .update_valid     (tbl_update_valid),
        .update_upc       (tbl_update_upc),
        .update_upct_index(tbl_update_index)
    );

    target_expander u_expander (
        .CLK           (CLK),
        .nRST          (nRST),
        .read_valid    (read_valid),
        .read_target   (read_target),
        .tbl_read_valid(tbl_read_valid),
        .tbl_read_index(tbl_read_index),
        .tbl_read_upc  (tbl_read_upc),
        .expanded      (expanded)
    );

endmodule

/* tb_pc_table.sv */
/*
 * Testbench for pc_table_top.
 * Strobes are driven on rising edges. Each result is checked on the
 * falling edge one cycle later against a reference model of the table.
 * The model's table and tree are kept in step with every driven cycle.
 * Stimulus is repeatable, $urandom is seeded once with 73.
 */

module tb_pc_table;

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------------------
    // run length
    // ------------------------------------------------------------------------

    localparam int RANDOM_CYCLES = 300;
    // directed part with resets and drain, rounded up
    localparam int DIRECTED_CYCLES = 60;
    localparam int WATCHDOG_NS = (RANDOM_CYCLES + DIRECTED_CYCLES + 20) * 4;

    // victims of a fresh tree, in fill order
    localparam int FILL_ORDER [8] = '{0, 4, 2, 6, 1, 5, 3, 7};

    typedef pc_pkg::upc_t [upct_pkg::UPCT_ENTRIES-1:0] upc_tbl_t;

    // one cycle's worth of expected outputs
    typedef struct packed {
        logic                 comp_valid;
        pc_pkg::comp_target_t comp;
        pc_pkg::full_target_t full;
    } expect_t;

    // ------------------------------------------------------------------------
    // signals
    // ------------------------------------------------------------------------

    logic                 CLK;
    logic                 nRST;
    logic                 update_valid;
    pc_pkg::pc_t          update_pc;
    logic                 comp_valid;
    pc_pkg::comp_target_t comp_target;
    logic                 read_valid;
    pc_pkg::comp_target_t read_target;
    pc_pkg::full_target_t expanded;

    // reference model state
    upc_tbl_t            model_tbl;
    upct_pkg::plru_t     model_tree;
    upct_pkg::upct_idx_t model_idx;

    // pending expectations, one per driven cycle
    expect_t exp_q [$];
    string   name_q [$];

    int checks;
    int value_errors;
    int valid_errors;

    // stimulus values
    pc_pkg::upc_t fill_upc [8];
    pc_pkg::upc_t pool [12];

    pc_table_top UUT (
        .CLK         (CLK),
        .nRST        (nRST),
        .update_valid(update_valid),
        .update_pc   (update_pc),
        .comp_valid  (comp_valid),
        .comp_target (comp_target),
        .read_valid  (read_valid),
        .read_target (read_target),
        .expanded    (expanded)
    );

    // 4 ns period
    always #2 CLK = ~CLK;

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    // follow the tree bits from the root, leaf number is the victim
    function automatic upct_pkg::upct_idx_t tree_victim(input upct_pkg::plru_t tree);
        upct_pkg::upct_idx_t idx;
        int                  node;
        idx  = '0;
        node = 0;
        for (int lvl = 0; lvl < upct_pkg::UPCT_IDX_WIDTH; lvl++) begin
            idx  = {idx[upct_pkg::UPCT_IDX_WIDTH-2:0], tree[node]};
            node = tree[node] ? 2 * node + 2 : 2 * node + 1;
        end
        return idx;
    endfunction

    // every node on the path to idx ends up pointing the other way
    function automatic upct_pkg::plru_t tree_touch(
        input upct_pkg::plru_t     tree,
        input upct_pkg::upct_idx_t idx
    );
        int   node;
        logic right;
        node = 0;
        for (int lvl = 0; lvl < upct_pkg::UPCT_IDX_WIDTH; lvl++) begin
            right      = idx[upct_pkg::UPCT_IDX_WIDTH-1-lvl];
            tree[node] = ~right;
            node       = right ? 2 * node + 2 : 2 * node + 1;
        end
        return tree;
    endfunction

    // one table cycle: hit, else fill, else read refresh
    // duplicate hits give the OR of their indices
    function automatic upct_pkg::upct_idx_t ref_update(
        input logic                upd,
        input pc_pkg::upc_t        upc,
        input logic                rd,
        input upct_pkg::upct_idx_t rd_idx,
        inout upc_tbl_t            tbl,
        inout upct_pkg::plru_t     tree
    );
        logic                hit;
        upct_pkg::upct_idx_t idx;
        hit = 1'b0;
        idx = '0;
        for (int i = 0; i < upct_pkg::UPCT_ENTRIES; i++) begin
            if (tbl[i] == upc) begin
                hit = 1'b1;
                idx = idx | upct_pkg::upct_idx_t'(i);
            end
        end
        if (upd && hit) begin
            tree = tree_touch(tree, idx);
        end
        else if (upd) begin
            idx      = tree_victim(tree);
            tbl[idx] = upc;
            tree     = tree_touch(tree, idx);
        end
        else if (rd) begin
            tree = tree_touch(tree, rd_idx);
        end
        return idx;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic drive_cycle(
        input string               name,
        input logic                uv,
        input pc_pkg::pc_t         pc,
        input logic                rv,
        input upct_pkg::upct_idx_t rd_idx,
        input pc_pkg::lpc_t        rd_lpc
    );
        expect_t              e;
        pc_pkg::comp_target_t rt;
        pc_pkg::upc_t         upc;
        rt.index = rd_idx;
        rt.lpc   = rd_lpc;
        upc      = pc[pc_pkg::PC_WIDTH-1:pc_pkg::LPC_WIDTH];
        @(posedge CLK);
        update_valid <= uv;
        update_pc    <= pc;
        read_valid   <= rv;
        read_target  <= rt;
        // read sees the table as it was before this cycle's update
        e.full.valid = rv;
        e.full.pc    = {model_tbl[rd_idx], rd_lpc};
        model_idx    = ref_update(uv, upc, rv, rd_idx, model_tbl, model_tree);
        e.comp_valid = uv;
        e.comp.index = model_idx;
        e.comp.lpc   = pc[pc_pkg::LPC_WIDTH-1:0];
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle("idle", 1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic read_entry(input string name, input upct_pkg::upct_idx_t idx);
        drive_cycle(name, 1'b0, '0, 1'b1, idx, pc_pkg::lpc_t'($urandom));
    endtask

    task automatic update_upc(input string name, input pc_pkg::upc_t upc);
        drive_cycle(name, 1'b1, {upc, pc_pkg::lpc_t'($urandom)}, 1'b0, '0, '0);
    endtask

    // two idle cycles first so no result is cleared in flight
    task automatic apply_reset(input int cycles);
        idle_cycles(2);
        nRST       <= 1'b0;
        model_tbl  = '0;
        model_tree = '0;
        idle_cycles(cycles);
        nRST <= 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------------

    task automatic check_comp(
        input string                name,
        input pc_pkg::comp_target_t exp,
        input pc_pkg::comp_target_t act
    );
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Error %s: expected index %0d lpc %h, actual index %0d lpc %h",
                     name, exp.index, exp.lpc, act.index, act.lpc);
        end
    endtask

    task automatic check_full(
        input string                name,
        input pc_pkg::full_target_t exp,
        input pc_pkg::full_target_t act
    );
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Error %s: expected pc %h, actual pc %h", name, exp.pc, act.pc);
        end
    endtask

    // results of the cycle driven one edge before the latest one
    always @(negedge CLK) begin : compare_outputs
        expect_t e;
        string   name;
        if (exp_q.size() >= 2) begin
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            if (comp_valid !== e.comp_valid) begin
                valid_errors++;
                if (e.comp_valid) begin
                    $display("%s: no compressed target one cycle after the update", name);
                end
                else begin
                    $display("%s: compressed target appeared without an update", name);
                end
            end
            else if (e.comp_valid) begin
                check_comp(name, e.comp, comp_target);
            end
            if (expanded.valid !== e.full.valid) begin
                valid_errors++;
                if (e.full.valid) begin
                    $display("%s: no expanded PC one cycle after the read", name);
                end
                else begin
                    $display("%s: expanded PC appeared without a read", name);
                end
            end
            else if (e.full.valid) begin
                check_full(name, e.full, expanded);
            end
        end
    end

    // hard stop if the run stalls
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin : run_tests
        upct_pkg::upct_idx_t v;
        CLK          = 1'b0;
        nRST         = 1'b0;
        update_valid = 1'b0;
        update_pc    = '0;
        read_valid   = 1'b0;
        read_target  = '0;
        model_tbl    = '0;
        model_tree   = '0;
        model_idx    = '0;
        checks       = 0;
        value_errors = 0;
        valid_errors = 0;
        void'($urandom(73));

        // fill values nonzero and distinct, bit 3 always set
        for (int i = 0; i < 8; i++) begin
            fill_upc[i] = {18'($urandom), 1'b1, 3'(i)};
        end
        // random pool, entry 0 is the reset upc
        pool[0] = '0;
        for (int i = 1; i < 12; i++) begin
            pool[i] = {4'(i), 18'($urandom)};
        end

        // after reset, nothing valid and every entry reads zero
        idle_cycles(3);
        nRST <= 1'b1;
        @(negedge CLK);
        if (comp_valid !== 1'b0 || expanded.valid !== 1'b0) begin
            valid_errors++;
            $display("outputs are not idle after reset");
        end
        for (int i = 0; i < 8; i++) begin
            read_entry("reset_read", upct_pkg::upct_idx_t'(i));
        end

        // fresh tree, fills follow the tree order
        apply_reset(3);
        for (int i = 0; i < 8; i++) begin
            update_upc("fill_order", fill_upc[i]);
            if (int'(model_idx) != FILL_ORDER[i]) begin
                value_errors++;
                $display("Error fill_order: expected %0d actual %0d", FILL_ORDER[i], model_idx);
            end
        end

        // hits keep their index, readback shows nothing was written
        update_upc("hit", fill_upc[5]);
        update_upc("hit", fill_upc[0]);
        update_upc("hit", fill_upc[7]);
        for (int i = 0; i < 8; i++) begin
            read_entry("hit_readback", upct_pkg::upct_idx_t'(i));
        end

        // reads steer the victim
        read_entry("victim_touch", 3'd3);
        read_entry("victim_touch", 3'd6);
        update_upc("victim_miss", 22'h3abc5);
        read_entry("victim_read", model_idx);

        // read of the entry being replaced in the same cycle
        v = tree_victim(model_tree);
        drive_cycle("same_cycle", 1'b1, {22'h2f0f0, 10'h155}, 1'b1, v, 10'h2aa);
        read_entry("same_cycle_after", v);
        // read from the other half of the tree beside a fill
        // the next miss shows which of the two moved the tree
        v = tree_victim(model_tree);
        drive_cycle("same_cycle_tree", 1'b1, {22'h0c3c3, 10'h0f0}, 1'b1, v ^ 3'd4, 10'h30f);
        update_upc("same_cycle_next_miss", 22'h15a52);

        // all entries zero, so the OR rule decides the index
        apply_reset(3);
        update_upc("zero_or_rule", '0);

        // random mix over a small pool
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            drive_cycle("random", 1'($urandom), {pool[$urandom % 12], pc_pkg::lpc_t'($urandom)},
                        1'($urandom), upct_pkg::upct_idx_t'($urandom),
                        pc_pkg::lpc_t'($urandom));
        end

        // drain the last results
        idle_cycles(3);
        @(negedge CLK);
        #1;
        $display("checks %0d, value errors %0d, valid errors %0d",
                 checks, value_errors, valid_errors);
        if (value_errors == 0 && valid_errors == 0) begin
            $display("TEST RESULT: PASS");
        end
        else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
upct_pkg.sv
pc_pkg.sv
one_hot_enc.sv
plru_updater.sv
upct.sv
target_compressor.sv
target_expander.sv
pc_table_top.sv
tb_pc_table.sv

/* Bender.yml */
package:
  name: pc_table

sources:
  - upct_pkg.sv
  - pc_pkg.sv
  - one_hot_enc.sv
  - plru_updater.sv
  - upct.sv
  - target_compressor.sv
  - target_expander.sv
  - pc_table_top.sv
  - target: test
    files:
      - tb_pc_table.sv
